// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_num_t;

    // one LA32R word, read through whichever field layout the opcode calls for
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            reg_num_t    rk;
            reg_num_t    rj;
            reg_num_t    rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            reg_num_t    rj;
            reg_num_t    rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm;
            reg_num_t    rd;
        } fmt_1ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs;
            reg_num_t    rj;
            reg_num_t    rd;
        } fmt_2ri16;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
    } instr_word_t;

    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w = 10'h0a2;
    localparam logic [9:0] op_st_w = 10'h0a6;
    localparam logic [6:0] op_lu12i_w = 7'h0a;
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bne = 6'h17;
    localparam logic [5:0] op_b = 6'h14;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_t;

    typedef enum logic {wb_from_alu, wb_from_mem} wb_sel_t;

    // add.w r0, r0, r0
    localparam word_t nop_instr = 32'h0010_0000;

endpackage

// ==== design/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter int width = 32
) (
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             valid_in,
    input  logic [width-1:0] data_in,
    input  logic             ready_go,
    input  logic             allow_out,
    output logic             allow_in,
    output logic             valid_out,
    output logic [width-1:0] data_out,
    input  logic             flush
);

    assign allow_in = !valid_out || (ready_go && allow_out);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else if (allow_in) begin
            valid_out <= valid_in;
        end else if (flush) begin
            // blocked entry dropped in place
            valid_out <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (valid_in && allow_in) begin
            data_out <= data_in;
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = 32'h1c00_0000
) (
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        id_allow_in,
    input  logic        branch_taken,
    input  word_t       branch_target,
    input  logic        inst_addr_ok,
    input  logic        inst_data_ok,
    input  word_t       inst_rdata,
    output logic        inst_req,
    output word_t       inst_addr,
    output logic        if_valid,
    output word_t       if_pc,
    output instr_word_t if_instr
);

    logic  fetch_en;
    logic  discard;
    word_t next_pc;
    logic  redirect;
    logic  if_stage_valid;
    logic  if_ready_go;
    logic  if_allow_in;
    logic  hold_valid;
    word_t hold_instr;

    // a taken branch counts only in the cycle it leaves decode
    assign redirect = branch_taken && id_allow_in;

    assign inst_addr = redirect ? branch_target : next_pc;
    assign inst_req = fetch_en && !discard && if_allow_in;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_en <= 1'b0;
            next_pc <= reset_pc;
        end else begin
            fetch_en <= 1'b1;
            if (inst_req && inst_addr_ok) begin
                next_pc <= inst_addr + 32'd4;
            end else if (redirect) begin
                next_pc <= branch_target;
            end
        end
    end

    // wrong-path fetch still in flight, drop its response
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            discard <= 1'b0;
        end else if (redirect && if_stage_valid && !if_ready_go) begin
            discard <= 1'b1;
        end else if (inst_data_ok) begin
            discard <= 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            hold_valid <= 1'b0;
        end else if (id_allow_in) begin
            hold_valid <= 1'b0;
        end else if (if_stage_valid && inst_data_ok) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_data_ok && !hold_valid) begin
            hold_instr <= inst_rdata;
        end
    end

    assign if_ready_go = inst_data_ok || hold_valid;
    assign if_valid = if_stage_valid && if_ready_go && !redirect;
    assign if_instr = hold_valid ? hold_instr : inst_rdata;

    pipe_stage #(.width(xlen)) pc_stage_i (
        .aclk(aclk), .arst_n(arst_n),
        .valid_in(inst_req && inst_addr_ok), .data_in(inst_addr),
        .ready_go(if_ready_go), .allow_out(id_allow_in),
        .allow_in(if_allow_in), .valid_out(if_stage_valid), .data_out(if_pc),
        .flush(redirect)
    );

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import cpu_pkg::*;
(
    input  logic     aclk,
    input  logic     arst_n,
    input  reg_num_t rj_num,
    input  reg_num_t rk_num,
    input  reg_num_t rd_num,
    input  logic     wen,
    input  reg_num_t wnum,
    input  word_t    wdata,
    output word_t    rj_val,
    output word_t    rk_val,
    output word_t    rd_val
);

    word_t regs [2**reg_addr_w];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wnum != '0) begin
            regs[wnum] <= wdata;
        end
    end

    assign rj_val = regs[rj_num];
    assign rk_val = regs[rk_num];
    assign rd_val = regs[rd_num];

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit
    import cpu_pkg::*;
(
    input  logic        id_valid,
    input  word_t       id_pc,
    input  instr_word_t id_instr,
    input  word_t       rj_val,
    input  word_t       rk_val,
    input  word_t       rd_val,
    input  logic        ex_valid,
    input  logic        ex_wen,
    input  reg_num_t    ex_dest,
    input  logic        mem_valid,
    input  logic        mem_wen,
    input  logic        mem_is_load,
    input  reg_num_t    mem_dest,
    input  word_t       mem_result,
    input  logic        wb_wen,
    input  reg_num_t    wb_dest,
    input  word_t       wb_value,
    output reg_num_t    rj_num,
    output reg_num_t    rk_num,
    output reg_num_t    rd_num,
    output word_t       src_a,
    output word_t       src_b,
    output word_t       store_data,
    output reg_num_t    dest,
    output alu_op_t     alu_op,
    output logic        mem_rd,
    output logic        mem_wr,
    output wb_sel_t     wb_sel,
    output logic        reg_wen,
    output logic        id_ready_go,
    output logic        branch_taken,
    output word_t       branch_target
);

    instr_word_t instr;
    logic        is_add, is_sub, is_addi, is_lu12i, is_ld, is_st;
    logic        is_beq, is_bne, is_b;
    logic        use_rj, use_rk, use_rd;
    word_t       rj_fwd, rk_fwd, rd_fwd;
    word_t       imm;
    word_t       br_offs;
    logic        hazard;

    // newest value of a source: mem stage alu result, then write-back, then file
    function automatic word_t forward(input reg_num_t num, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (num != '0) begin
            if (mem_valid && mem_wen && !mem_is_load && mem_dest == num) begin
                val = mem_result;
            end else if (wb_wen && wb_dest == num) begin
                val = wb_value;
            end
        end
        return val;
    endfunction

    function automatic logic hits_source(input logic wen, input reg_num_t wnum);
        return wen && wnum != '0 && ((use_rj && wnum == rj_num) ||
            (use_rk && wnum == rk_num) || (use_rd && wnum == rd_num));
    endfunction

    // empty stage decodes as a nop
    assign instr = id_valid ? id_instr : instr_word_t'(nop_instr);

    assign is_add = instr.fmt_3r.opcode == op_add_w;
    assign is_sub = instr.fmt_3r.opcode == op_sub_w;
    assign is_addi = instr.fmt_2ri12.opcode == op_addi_w;
    assign is_ld = instr.fmt_2ri12.opcode == op_ld_w;
    assign is_st = instr.fmt_2ri12.opcode == op_st_w;
    assign is_lu12i = instr.fmt_1ri20.opcode == op_lu12i_w;
    assign is_beq = instr.fmt_2ri16.opcode == op_beq;
    assign is_bne = instr.fmt_2ri16.opcode == op_bne;
    assign is_b = instr.fmt_i26.opcode == op_b;

    assign rj_num = instr.fmt_3r.rj;
    assign rk_num = instr.fmt_3r.rk;
    assign rd_num = instr.fmt_3r.rd;

    assign use_rj = is_add || is_sub || is_addi || is_ld || is_st || is_beq || is_bne;
    assign use_rk = is_add || is_sub;
    // st.w data and branch compare read rd
    assign use_rd = is_st || is_beq || is_bne;

    always_comb begin
        rj_fwd = forward(rj_num, rj_val);
        rk_fwd = forward(rk_num, rk_val);
        rd_fwd = forward(rd_num, rd_val);
        hazard = hits_source(ex_valid && ex_wen, ex_dest) ||
            hits_source(mem_valid && mem_wen && mem_is_load, mem_dest);
    end

    assign id_ready_go = !hazard;

    assign imm = is_lu12i ? {instr.fmt_1ri20.imm, 12'b0} :
        {{20{instr.fmt_2ri12.imm[11]}}, instr.fmt_2ri12.imm};

    assign src_a = rj_fwd;
    assign src_b = use_rk ? rk_fwd : imm;
    assign store_data = rd_fwd;
    assign dest = rd_num;
    assign alu_op = is_sub ? alu_sub : (is_lu12i ? alu_pass_b : alu_add);
    assign mem_rd = is_ld;
    assign mem_wr = is_st;
    assign wb_sel = is_ld ? wb_from_mem : wb_from_alu;
    assign reg_wen = (is_add || is_sub || is_addi || is_lu12i || is_ld) && rd_num != '0;

    // offsets count words
    assign br_offs = is_b ?
        {{4{instr.fmt_i26.offs_hi[9]}}, instr.fmt_i26.offs_hi, instr.fmt_i26.offs_lo, 2'b00} :
        {{14{instr.fmt_2ri16.offs[15]}}, instr.fmt_2ri16.offs, 2'b00};

    assign branch_target = id_pc + br_offs;
    assign branch_taken = is_b || (is_beq && rj_fwd == rd_fwd) || (is_bne && rj_fwd != rd_fwd);

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit
    import cpu_pkg::*;
(
    input  logic    ex_valid,
    input  word_t   src_a,
    input  word_t   src_b,
    input  word_t   store_data,
    input  alu_op_t alu_op,
    input  logic    mem_rd,
    input  logic    mem_wr,
    input  logic    mem_allow_in,
    input  logic    data_addr_ok,
    output word_t   alu_result,
    output logic    data_req,
    output logic    data_wr,
    output word_t   data_addr,
    output word_t   data_wdata,
    output logic    ex_ready_go
);

    word_t sum;
    logic  is_access;

    assign sum = src_a + src_b;

    always_comb begin
        case (alu_op)
            alu_sub: alu_result = src_a - src_b;
            alu_pass_b: alu_result = src_b;
            default: alu_result = sum;
        endcase
    end

    assign is_access = mem_rd || mem_wr;

    // only ask while the memory stage has room for the response
    assign data_req = ex_valid && is_access && mem_allow_in;
    assign data_wr = ex_valid && mem_wr;
    assign data_addr = sum;
    assign data_wdata = store_data;

    assign ex_ready_go = !is_access || (data_req && data_addr_ok);

endmodule

// ==== design/mem_response.sv ====
`timescale 1ns/1ps

module mem_response
    import cpu_pkg::*;
(
    input  logic  aclk,
    input  logic  arst_n,
    input  logic  mem_valid,
    input  logic  mem_is_access,
    input  logic  wb_allow_in,
    input  logic  data_data_ok,
    input  word_t data_rdata,
    output word_t load_data,
    output logic  mem_ready_go
);

    logic  held_valid;
    word_t held_data;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            held_valid <= 1'b0;
        end else if (wb_allow_in) begin
            held_valid <= 1'b0;
        end else if (mem_valid && mem_is_access && data_data_ok) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (data_data_ok && !held_valid) begin
            held_data <= data_rdata;
        end
    end

    assign load_data = held_valid ? held_data : data_rdata;
    assign mem_ready_go = !mem_is_access || data_data_ok || held_valid;

endmodule

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
#(
    parameter word_t reset_pc = 32'h1c00_0000
) (
    input  logic     aclk,
    input  logic     arst_n,
    output logic     inst_req,
    output word_t    inst_addr,
    input  logic     inst_addr_ok,
    input  logic     inst_data_ok,
    input  word_t    inst_rdata,
    output logic     data_req,
    output logic     data_wr,
    output word_t    data_addr,
    output word_t    data_wdata,
    input  logic     data_addr_ok,
    input  logic     data_data_ok,
    input  word_t    data_rdata,
    output word_t    debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_num_t debug_wb_rf_wnum,
    output word_t    debug_wb_rf_wdata
);

    localparam int id_w = 2 * xlen;
    localparam int ex_w = 4 * xlen + reg_addr_w + 6;
    localparam int mem_w = 2 * xlen + reg_addr_w + 3;
    localparam int wb_w = 3 * xlen + reg_addr_w + 2;

    logic        if_valid;
    word_t       if_pc;
    instr_word_t if_instr;
    logic        branch_taken;
    word_t       branch_target;

    logic            id_allow_in, id_valid, id_ready_go;
    logic [id_w-1:0] id_q;
    word_t           id_pc;
    instr_word_t     id_instr;
    reg_num_t        rj_num, rk_num, rd_num;
    word_t           rj_val, rk_val, rd_val;
    word_t           id_src_a, id_src_b, id_store_data;
    reg_num_t        id_dest;
    alu_op_t         id_alu_op;
    logic            id_mem_rd, id_mem_wr, id_reg_wen;
    wb_sel_t         id_wb_sel;

    logic            ex_allow_in, ex_valid, ex_ready_go;
    logic [ex_w-1:0] ex_q;
    word_t           ex_pc, ex_src_a, ex_src_b, ex_store_data, ex_result;
    reg_num_t        ex_dest;
    logic [1:0]      ex_alu_op;
    logic            ex_mem_rd, ex_mem_wr, ex_wb_sel, ex_reg_wen;

    logic             mem_allow_in, mem_valid, mem_ready_go;
    logic [mem_w-1:0] mem_q;
    word_t            mem_pc, mem_result, mem_load_data;
    reg_num_t         mem_dest;
    logic             mem_reg_wen, mem_wb_sel, mem_is_access;

    logic            wb_allow_in, wb_valid;
    logic [wb_w-1:0] wb_q;
    word_t           wb_pc, wb_result, wb_load_data, wb_value;
    reg_num_t        wb_dest;
    logic            wb_reg_wen, wb_wb_sel, rf_wen;

    fetch_unit #(.reset_pc(reset_pc)) fetch_i (
        .aclk(aclk), .arst_n(arst_n), .id_allow_in(id_allow_in),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .inst_addr_ok(inst_addr_ok), .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .inst_req(inst_req), .inst_addr(inst_addr),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    pipe_stage #(.width(id_w)) id_stage_i (
        .aclk(aclk), .arst_n(arst_n), .valid_in(if_valid), .data_in({if_pc, if_instr}),
        .ready_go(id_ready_go), .allow_out(ex_allow_in),
        .allow_in(id_allow_in), .valid_out(id_valid), .data_out(id_q), .flush(1'b0)
    );

    assign {id_pc, id_instr} = id_q;

    decode_unit decode_i (
        .id_valid(id_valid), .id_pc(id_pc), .id_instr(id_instr),
        .rj_val(rj_val), .rk_val(rk_val), .rd_val(rd_val),
        .ex_valid(ex_valid), .ex_wen(ex_reg_wen), .ex_dest(ex_dest),
        .mem_valid(mem_valid), .mem_wen(mem_reg_wen),
        .mem_is_load(mem_wb_sel == wb_from_mem), .mem_dest(mem_dest), .mem_result(mem_result),
        .wb_wen(rf_wen), .wb_dest(wb_dest), .wb_value(wb_value),
        .rj_num(rj_num), .rk_num(rk_num), .rd_num(rd_num),
        .src_a(id_src_a), .src_b(id_src_b), .store_data(id_store_data), .dest(id_dest),
        .alu_op(id_alu_op), .mem_rd(id_mem_rd), .mem_wr(id_mem_wr),
        .wb_sel(id_wb_sel), .reg_wen(id_reg_wen), .id_ready_go(id_ready_go),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    reg_file rf_i (
        .aclk(aclk), .arst_n(arst_n),
        .rj_num(rj_num), .rk_num(rk_num), .rd_num(rd_num),
        .wen(rf_wen), .wnum(wb_dest), .wdata(wb_value),
        .rj_val(rj_val), .rk_val(rk_val), .rd_val(rd_val)
    );

    pipe_stage #(.width(ex_w)) ex_stage_i (
        .aclk(aclk), .arst_n(arst_n), .valid_in(id_valid && id_ready_go),
        .data_in({id_pc, id_src_a, id_src_b, id_store_data, id_dest, id_alu_op,
            id_mem_rd, id_mem_wr, id_wb_sel, id_reg_wen}),
        .ready_go(ex_ready_go), .allow_out(mem_allow_in),
        .allow_in(ex_allow_in), .valid_out(ex_valid), .data_out(ex_q), .flush(1'b0)
    );

    assign {ex_pc, ex_src_a, ex_src_b, ex_store_data, ex_dest, ex_alu_op,
        ex_mem_rd, ex_mem_wr, ex_wb_sel, ex_reg_wen} = ex_q;

    execute_unit execute_i (
        .ex_valid(ex_valid), .src_a(ex_src_a), .src_b(ex_src_b),
        .store_data(ex_store_data), .alu_op(alu_op_t'(ex_alu_op)),
        .mem_rd(ex_mem_rd), .mem_wr(ex_mem_wr),
        .mem_allow_in(mem_allow_in), .data_addr_ok(data_addr_ok),
        .alu_result(ex_result), .data_req(data_req), .data_wr(data_wr),
        .data_addr(data_addr), .data_wdata(data_wdata), .ex_ready_go(ex_ready_go)
    );

    pipe_stage #(.width(mem_w)) mem_stage_i (
        .aclk(aclk), .arst_n(arst_n), .valid_in(ex_valid && ex_ready_go),
        .data_in({ex_pc, ex_result, ex_dest, ex_reg_wen, ex_wb_sel, ex_mem_rd || ex_mem_wr}),
        .ready_go(mem_ready_go), .allow_out(wb_allow_in),
        .allow_in(mem_allow_in), .valid_out(mem_valid), .data_out(mem_q), .flush(1'b0)
    );

    assign {mem_pc, mem_result, mem_dest, mem_reg_wen, mem_wb_sel, mem_is_access} = mem_q;

    mem_response mem_resp_i (
        .aclk(aclk), .arst_n(arst_n), .mem_valid(mem_valid),
        .mem_is_access(mem_is_access), .wb_allow_in(wb_allow_in),
        .data_data_ok(data_data_ok), .data_rdata(data_rdata),
        .load_data(mem_load_data), .mem_ready_go(mem_ready_go)
    );

    // write-back retires every cycle
    pipe_stage #(.width(wb_w)) wb_stage_i (
        .aclk(aclk), .arst_n(arst_n), .valid_in(mem_valid && mem_ready_go),
        .data_in({mem_pc, mem_result, mem_load_data, mem_dest, mem_reg_wen, mem_wb_sel}),
        .ready_go(1'b1), .allow_out(1'b1),
        .allow_in(wb_allow_in), .valid_out(wb_valid), .data_out(wb_q), .flush(1'b0)
    );

    assign {wb_pc, wb_result, wb_load_data, wb_dest, wb_reg_wen, wb_wb_sel} = wb_q;

    assign wb_value = (wb_wb_sel == wb_from_mem) ? wb_load_data : wb_result;
    assign rf_wen = wb_valid && wb_reg_wen;

    assign debug_wb_pc = wb_pc;
    assign debug_wb_rf_wen = {4{rf_wen}};
    assign debug_wb_rf_wnum = wb_dest;
    assign debug_wb_rf_wdata = wb_value;

endmodule

// ==== tests/sram_model.sv ====
`timescale 1ns/1ps

module sram_model #(
    parameter int          addr_bits = 8,
    parameter logic [31:0] seed = 32'd66
) (
    input  logic        aclk,
    input  logic        arst_n,
    input  logic [31:0] init_mem [2**addr_bits],
    input  logic        req,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata
);

    logic [31:0] mem [2**addr_bits];
    logic [31:0] pending [$];
    logic [31:0] rnd;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**addr_bits; i++) begin
                mem[i] <= init_mem[i];
            end
            pending.delete();
            rnd = seed;
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            rdata <= '0;
        end else begin
            rnd = lcg_next(rnd);
            // access happens at acceptance, the answer queues up in order
            if (req && addr_ok) begin
                if (wr) begin
                    mem[addr[addr_bits+1:2]] <= wdata;
                end
                pending.push_back(mem[addr[addr_bits+1:2]]);
            end
            addr_ok <= rnd[17:16] != 2'b00;
            if (pending.size() > 0 && rnd[20:19] != 2'b00) begin
                data_ok <= 1'b1;
                rdata <= pending.pop_front();
            end else begin
                data_ok <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_cpu_core.sv ====
`timescale 1ns/1ps

module tb_cpu_core;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;
    localparam int          mem_bits = 8;
    localparam int          mem_words = 2**mem_bits;
    localparam logic [31:0] lcg_seed = 32'd66;
    localparam int          run_timeout = 5000;
    localparam int          quiet_cycles = 40;

    // writing ops come first, see run_reference
    localparam int i_add = 0;
    localparam int i_sub = 1;
    localparam int i_addi = 2;
    localparam int i_lu12i = 3;
    localparam int i_ld = 4;
    localparam int i_st = 5;
    localparam int i_beq = 6;
    localparam int i_bne = 7;
    localparam int i_b = 8;

    logic        aclk;
    logic        arst_n;
    logic        inst_req, inst_addr_ok, inst_data_ok;
    logic [31:0] inst_addr, inst_rdata;
    logic        data_req, data_wr, data_addr_ok, data_data_ok;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem_image [mem_words];
    logic [31:0] dmem_image [mem_words];
    logic [31:0] ref_dmem [mem_words];

    int          p_op [64];
    logic [4:0]  p_rd [64];
    logic [4:0]  p_rj [64];
    logic [4:0]  p_rk [64];
    int          p_imm [64];
    int          n_instr;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    int          n_seen;
    int          trace_errors;
    int          mem_errors;

    cpu_core #(.reset_pc(reset_pc)) dut_i (.*);

    sram_model #(.addr_bits(mem_bits), .seed(lcg_seed)) inst_mem_i (
        .aclk(aclk), .arst_n(arst_n), .init_mem(imem_image),
        .req(inst_req), .wr(1'b0), .addr(inst_addr), .wdata(32'h0),
        .addr_ok(inst_addr_ok), .data_ok(inst_data_ok), .rdata(inst_rdata)
    );

    sram_model #(.addr_bits(mem_bits), .seed(lcg_seed)) data_mem_i (
        .aclk(aclk), .arst_n(arst_n), .init_mem(dmem_image),
        .req(data_req), .wr(data_wr), .addr(data_addr), .wdata(data_wdata),
        .addr_ok(data_addr_ok), .data_ok(data_data_ok), .rdata(data_rdata)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    // LA32R encodings
    function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
            input logic [4:0] rj, input logic [4:0] rk, input int imm);
        case (op)
            i_add: return {17'h00020, rk, rj, rd};
            i_sub: return {17'h00022, rk, rj, rd};
            i_addi: return {10'h00a, imm[11:0], rj, rd};
            i_lu12i: return {7'h0a, imm[19:0], rd};
            i_ld: return {10'h0a2, imm[11:0], rj, rd};
            i_st: return {10'h0a6, imm[11:0], rj, rd};
            i_beq: return {6'h16, imm[15:0], rj, rd};
            i_bne: return {6'h17, imm[15:0], rj, rd};
            default: return {6'h14, imm[15:0], imm[25:16]};
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5a00_0000 + (idx << 2);
    endfunction

    task automatic add_instr(input int op, input int rd, input int rj, input int rk,
            input int imm);
        p_op[n_instr] = op;
        p_rd[n_instr] = rd[4:0];
        p_rj[n_instr] = rj[4:0];
        p_rk[n_instr] = rk[4:0];
        p_imm[n_instr] = imm;
        n_instr++;
    endtask

    task automatic load_program();
        add_instr(i_lu12i, 1, 0, 0, 'h12345);
        add_instr(i_addi, 1, 1, 0, 'h678);
        add_instr(i_addi, 2, 0, 0, 5);
        add_instr(i_add, 3, 1, 2, 0);
        add_instr(i_sub, 4, 3, 1, 0);
        add_instr(i_addi, 5, 0, 0, 'h40);
        add_instr(i_st, 3, 5, 0, 0);
        add_instr(i_ld, 6, 5, 0, 0);
        // load-use pairs
        add_instr(i_add, 7, 6, 6, 0);
        add_instr(i_ld, 8, 5, 0, 8);
        add_instr(i_sub, 9, 8, 2, 0);
        add_instr(i_addi, 10, 0, 0, 3);
        add_instr(i_addi, 11, 0, 0, 0);
        // three-pass loop
        add_instr(i_add, 11, 11, 10, 0);
        add_instr(i_addi, 10, 10, 0, -1);
        add_instr(i_bne, 0, 10, 0, -2);
        add_instr(i_st, 11, 5, 0, 4);
        add_instr(i_beq, 11, 11, 0, 3);
        add_instr(i_addi, 12, 0, 0, 'h111);
        add_instr(i_addi, 13, 0, 0, 'h222);
        add_instr(i_b, 0, 0, 0, 2);
        add_instr(i_addi, 14, 0, 0, 'h333);
        // not taken
        add_instr(i_beq, 2, 1, 0, 2);
        add_instr(i_addi, 15, 0, 0, -7);
        add_instr(i_ld, 16, 5, 0, 4);
        add_instr(i_st, 15, 5, 0, 12);
        add_instr(i_addi, 17, 16, 0, 1);
        add_instr(i_b, 0, 0, 0, 0);
    endtask

    // architectural run of the program, fills the expected trace and memory
    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] res;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        halted;
        int          idx;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < mem_words; i++) begin
            ref_dmem[i] = fill_word(i);
        end
        pc = reset_pc;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 1000) begin
            idx = (pc - reset_pc) >> 2;
            rd = p_rd[idx];
            rj = p_rj[idx];
            rk = p_rk[idx];
            next_pc = pc + 32'd4;
            res = 32'h0;
            addr = regs[rj] + p_imm[idx];
            case (p_op[idx])
                i_add: res = regs[rj] + regs[rk];
                i_sub: res = regs[rj] - regs[rk];
                i_addi: res = addr;
                i_lu12i: res = p_imm[idx] << 12;
                i_ld: res = ref_dmem[addr[mem_bits+1:2]];
                i_st: ref_dmem[addr[mem_bits+1:2]] = regs[rd];
                i_beq: if (regs[rj] == regs[rd]) next_pc = pc + (p_imm[idx] << 2);
                i_bne: if (regs[rj] != regs[rd]) next_pc = pc + (p_imm[idx] << 2);
                default: begin
                    next_pc = pc + (p_imm[idx] << 2);
                    halted = p_imm[idx] == 0;
                end
            endcase
            if (p_op[idx] <= i_ld && rd != 5'd0) begin
                regs[rd] = res;
                exp_pc.push_back(pc);
                exp_num.push_back(rd);
                exp_val.push_back(res);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            n_seen <= 0;
            trace_errors <= 0;
        end else if (debug_wb_rf_wen != 4'b0000) begin
            if (n_seen >= exp_pc.size()) begin
                $display("CHECK FAILED at %0t: extra write-back pc %h r%0d = %h",
                    $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
                trace_errors <= trace_errors + 1;
            end else if (debug_wb_rf_wen != 4'b1111 || debug_wb_pc != exp_pc[n_seen] ||
                    debug_wb_rf_wnum != exp_num[n_seen] ||
                    debug_wb_rf_wdata != exp_val[n_seen]) begin
                $display("CHECK FAILED at %0t: event %0d got pc %h r%0d = %h wen %b",
                    $time, n_seen, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                    debug_wb_rf_wen);
                $display("    expected pc %h r%0d = %h",
                    exp_pc[n_seen], exp_num[n_seen], exp_val[n_seen]);
                trace_errors <= trace_errors + 1;
            end
            n_seen <= n_seen + 1;
        end
    end

    initial begin
        int   cycles;
        logic timed_out;
        arst_n = 1'b0;
        n_instr = 0;
        mem_errors = 0;
        timed_out = 1'b0;
        load_program();
        // spare words hold addi r0 nops tagged with their index
        for (int i = 0; i < mem_words; i++) begin
            if (i < n_instr) begin
                imem_image[i] = encode(p_op[i], p_rd[i], p_rj[i], p_rk[i], p_imm[i]);
            end else begin
                imem_image[i] = encode(i_addi, 5'd0, 5'd0, 5'd0, i);
            end
            dmem_image[i] = fill_word(i);
        end
        run_reference();
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;
        cycles = 0;
        while (n_seen < exp_pc.size() && cycles < run_timeout) begin
            @(posedge aclk);
            cycles++;
        end
        if (n_seen < exp_pc.size()) begin
            $display("timeout: only %0d of %0d write-back events seen after %0d cycles",
                n_seen, exp_pc.size(), cycles);
            timed_out = 1'b1;
        end else begin
            // window for duplicated or late events
            repeat (quiet_cycles) @(posedge aclk);
            for (int i = 0; i < mem_words; i++) begin
                if (data_mem_i.mem[i] != ref_dmem[i]) begin
                    $display("CHECK FAILED at %0t: data word %0d is %h, expected %h",
                        $time, i, data_mem_i.mem[i], ref_dmem[i]);
                    mem_errors++;
                end
            end
        end
        $display("trace errors: %0d, memory errors: %0d", trace_errors, mem_errors);
        if (!timed_out && trace_errors + mem_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
design/cpu_pkg.sv
design/pipe_stage.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/mem_response.sv
design/cpu_core.sv
tests/sram_model.sv
tests/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing -f filelist.f --top-module tb_cpu_core -o tb_cpu_core
./obj_dir/tb_cpu_core > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
